// ==== include/usrp_tx_settings.svh ====
// Build-time sizes for the transmit path: FIFO depth, packet size, slot count, rate width
`ifndef USRP_TX_SETTINGS_SVH
`define USRP_TX_SETTINGS_SVH

// Sample FIFO entries, one 16-bit word each
`define TX_FIFO_DEPTH 4096

// Words in one USB packet
// Also the free-space margin the host needs before a burst
`define TX_PACKET_WORDS 256

// I/Q slots, ordered i0 q0 i1 q1 i2 q2 i3 q3
`define TX_NUM_SLOTS 8

// Width of the DAC strobe divider value
`define TX_RATE_WIDTH 8

`endif

// ==== src/usrp_tx_pkg.sv ====
// Shared types of the transmit path: sample, slot index, FIFO level and strobe rate
`default_nettype none

`include "usrp_tx_settings.svh"

package usrp_tx_pkg;

   // One DAC sample, same width as a host bus word
   typedef logic [15:0] sample_t;

   // Slot index and slot count
   // Needs one spare code so a count of all slots fits
   typedef logic [$clog2(`TX_NUM_SLOTS + 1)-1:0] slot_t;

   // FIFO fill level, 0 up to and including full
   typedef logic [$clog2(`TX_FIFO_DEPTH + 1)-1:0] fifo_level_t;

   // Strobe divider, period is rate + 1 cycles
   typedef logic [`TX_RATE_WIDTH-1:0] rate_t;

endpackage

`default_nettype wire

// ==== src/tx_strobe_gen.sv ====
// DAC strobe generator: programmable txclk divider with a one-cycle pulse
`timescale 1ns/1ps
`default_nettype none

module tx_strobe_gen
(
   input  wire                  txclk,
   input  wire                  reset,
   input  wire                  tx_enable,
   input  usrp_tx_pkg::rate_t   rate,
   output logic                 txstrobe
);

   // Cycles left until the next strobe
   usrp_tx_pkg::rate_t count;

   // Down-counter reloads from rate on every pulse
   // While disabled it sits loaded, so the first pulse comes rate + 1 cycles after enable
   always_ff @(posedge txclk)
   begin
      if (reset || !tx_enable)
      begin
         count    <= rate;
         txstrobe <= 1'b0;
      end
      else if (count == '0)
      begin
         // Period ends here, a new rate value takes effect from this reload
         count    <= rate;
         txstrobe <= 1'b1;
      end
      else
      begin
         count    <= count - 1'b1;
         txstrobe <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== src/tx_packet_guard.sv ====
// Host write guard: per-burst word counter capping each burst at one packet, and have_space
`timescale 1ns/1ps
`default_nettype none

`include "usrp_tx_settings.svh"

module tx_packet_guard
(
   input  wire                       txclk,
   input  wire                       bus_reset,
   input  wire                       wr,
   input  usrp_tx_pkg::fifo_level_t  fifo_level,
   output logic                      wr_accept,
   output logic                      have_space
);

   // One extra bit, which doubles as the packet-full flag
   localparam int CNT_W = $clog2(`TX_PACKET_WORDS) + 1;

   // Highest fill level that still leaves room for a whole packet
   localparam usrp_tx_pkg::fifo_level_t SPACE_LIMIT =
      usrp_tx_pkg::fifo_level_t'(`TX_FIFO_DEPTH - 1 - `TX_PACKET_WORDS);

   logic [CNT_W-1:0] burst_count;
   logic             packet_done;

   // Top bit sets once a full packet has gone through
   assign packet_done = burst_count[CNT_W-1];

   // USB controller may tack an extra word onto a burst
   // Anything past one packet is thrown away here
   assign wr_accept = wr & ~packet_done;

   // Counter saturates at one packet
   // First idle cycle between bursts rearms it
   always_ff @(posedge txclk)
   begin
      if (bus_reset)
      begin
         burst_count <= '0;
      end
      else if (wr_accept)
      begin
         burst_count <= burst_count + 1'b1;
      end
      else if (!wr)
      begin
         burst_count <= '0;
      end
   end

   // Host starts a burst only while this is high
   assign have_space = (fifo_level <= SPACE_LIMIT);

endmodule

`default_nettype wire

// ==== src/tx_sample_fifo.sv ====
// Synchronous first-word-fall-through sample FIFO with registered head and fill level
`timescale 1ns/1ps
`default_nettype none

`include "usrp_tx_settings.svh"

module tx_sample_fifo
#(
   parameter int DEPTH = `TX_FIFO_DEPTH
)
(
   input  wire                       txclk,
   input  wire                       reset,
   input  wire                       wr_en,
   input  usrp_tx_pkg::sample_t      wr_data,
   input  wire                       rd_en,
   output usrp_tx_pkg::sample_t      rd_data,
   output logic                      empty,
   output logic                      full,
   output usrp_tx_pkg::fifo_level_t  level
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   // Sample storage
   usrp_tx_pkg::sample_t mem [DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W-1:0] rd_next;
   logic             wr_fire;
   logic             rd_fire;

   // Pointer advance, wraps also for a depth that is not a power of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1))
         return '0;
      else
         return ptr + 1'b1;
   endfunction

   assign empty = (level == '0);
   assign full  = (level == usrp_tx_pkg::fifo_level_t'(DEPTH));

   // Writes into a full FIFO are lost
   assign wr_fire = wr_en & ~full;
   assign rd_fire = rd_en & ~empty;

   // Address of the head word after this edge
   assign rd_next = rd_fire ? ptr_inc(rd_ptr) : rd_ptr;

   // RAM write port
   always_ff @(posedge txclk)
   begin
      if (wr_fire)
      begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // Head register
   // A word written into the slot that becomes the head goes straight through,
   // so a write to an empty FIFO shows on rd_data right after its edge
   always_ff @(posedge txclk)
   begin
      if (wr_fire && (wr_ptr == rd_next))
      begin
         rd_data <= wr_data;
      end
      else
      begin
         rd_data <= mem[rd_next];
      end
   end

   // Pointers and fill level
   always_ff @(posedge txclk)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end
      else
      begin
         if (wr_fire)
         begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         rd_ptr <= rd_next;
         // Level only moves when exactly one side fires
         case ({wr_fire, rd_fire})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - 1'b1;
            default: level <= level;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== src/tx_buffer.sv ====
// Frame loader: FIFO words into the I/Q slot registers, underrun flag and debug bus
`timescale 1ns/1ps
`default_nettype none

`include "usrp_tx_settings.svh"

module tx_buffer
(
   input  wire                    txclk,
   input  wire                    reset,
   // FIFO head, word valid while fifo_empty is low
   input  usrp_tx_pkg::sample_t   fifo_data,
   input  wire                    fifo_empty,
   output logic                   fifo_pop,
   // Number of slots in use per frame
   input  usrp_tx_pkg::slot_t     channels,
   input  wire                    txstrobe,
   input  wire                    clear_status,
   output usrp_tx_pkg::sample_t   tx_i_0,
   output usrp_tx_pkg::sample_t   tx_q_0,
   output usrp_tx_pkg::sample_t   tx_i_1,
   output usrp_tx_pkg::sample_t   tx_q_1,
   output usrp_tx_pkg::sample_t   tx_i_2,
   output usrp_tx_pkg::sample_t   tx_q_2,
   output usrp_tx_pkg::sample_t   tx_i_3,
   output usrp_tx_pkg::sample_t   tx_q_3,
   output logic                   tx_underrun,
   output logic [11:0]            debugbus
);

   localparam int SLOT_IDX_W = $clog2(`TX_NUM_SLOTS);

   // Next slot to fill, equals channels once the frame is complete
   usrp_tx_pkg::slot_t   load_next;
   logic                 frame_full;

   // Channel registers, i0 q0 i1 q1 i2 q2 i3 q3
   usrp_tx_pkg::sample_t slot_q [`TX_NUM_SLOTS];

   assign frame_full = (load_next == channels);

   // Take the head word whenever the frame still has room
   assign fifo_pop = ~frame_full & ~fifo_empty;

   // Sequencer
   always_ff @(posedge txclk)
   begin
      if (reset)
      begin
         load_next <= '0;
      end
      else if (fifo_pop)
      begin
         load_next <= load_next + 1'b1;
      end
      else if (txstrobe && frame_full)
      begin
         // DAC has taken the frame, start the next one
         load_next <= '0;
      end
   end

   // Slot registers
   // Unused slots keep their last value
   always_ff @(posedge txclk)
   begin
      if (reset)
      begin
         for (int i = 0; i < `TX_NUM_SLOTS; i++)
         begin
            slot_q[i] <= '0;
         end
      end
      else if (fifo_pop && (load_next < `TX_NUM_SLOTS))
      begin
         // Counts beyond the last slot pop words with nowhere to put them
         slot_q[load_next[SLOT_IDX_W-1:0]] <= fifo_data;
      end
   end

   assign tx_i_0 = slot_q[0];
   assign tx_q_0 = slot_q[1];
   assign tx_i_1 = slot_q[2];
   assign tx_q_1 = slot_q[3];
   assign tx_i_2 = slot_q[4];
   assign tx_q_2 = slot_q[5];
   assign tx_i_3 = slot_q[6];
   assign tx_q_3 = slot_q[7];

   // Underrun, strobe seen before the frame was complete
   // Sticky until the host clears it
   always_ff @(posedge txclk)
   begin
      if (reset)
      begin
         tx_underrun <= 1'b0;
      end
      else if (txstrobe && !frame_full)
      begin
         tx_underrun <= 1'b1;
      end
      else if (clear_status)
      begin
         tx_underrun <= 1'b0;
      end
   end

   // Debug bus
   assign debugbus[0]    = fifo_pop;
   assign debugbus[1]    = fifo_empty;
   assign debugbus[2]    = txstrobe;
   assign debugbus[3]    = tx_underrun;
   // Spare
   assign debugbus[7:4]  = 4'h0;
   assign debugbus[11:8] = load_next;

endmodule

`default_nettype wire

// ==== src/usrp_tx_top.sv ====
// Transmit path top level: packet guard, sample FIFO, frame loader and strobe generator
`timescale 1ns/1ps
`default_nettype none

module usrp_tx_top
(
   input  wire                    txclk,
   input  wire                    reset,
   // Host bus side
   input  wire                    bus_reset,
   input  usrp_tx_pkg::sample_t   usbdata,
   input  wire                    wr,
   output logic                   have_space,
   // Control and status
   input  usrp_tx_pkg::slot_t     channels,
   input  usrp_tx_pkg::rate_t     rate,
   input  wire                    tx_enable,
   input  wire                    clear_status,
   // DAC channel registers
   output usrp_tx_pkg::sample_t   tx_i_0,
   output usrp_tx_pkg::sample_t   tx_q_0,
   output usrp_tx_pkg::sample_t   tx_i_1,
   output usrp_tx_pkg::sample_t   tx_q_1,
   output usrp_tx_pkg::sample_t   tx_i_2,
   output usrp_tx_pkg::sample_t   tx_q_2,
   output usrp_tx_pkg::sample_t   tx_i_3,
   output usrp_tx_pkg::sample_t   tx_q_3,
   output logic                   tx_underrun,
   output logic                   tx_empty,
   output logic [11:0]            debugbus
);

   logic                      wr_accept;
   usrp_tx_pkg::fifo_level_t  fifo_level;
   usrp_tx_pkg::sample_t      fifo_data;
   logic                      fifo_empty;
   logic                      fifo_pop;
   logic                      txstrobe;

   // Burst cap and free-space flag
   tx_packet_guard u_guard
   (
      .txclk      (txclk),
      .bus_reset  (bus_reset),
      .wr         (wr),
      .fifo_level (fifo_level),
      .wr_accept  (wr_accept),
      .have_space (have_space)
   );

   // Full is never reached while the host honours have_space
   tx_sample_fifo u_fifo
   (
      .txclk   (txclk),
      .reset   (reset),
      .wr_en   (wr_accept),
      .wr_data (usbdata),
      .rd_en   (fifo_pop),
      .rd_data (fifo_data),
      .empty   (fifo_empty),
      .full    (),
      .level   (fifo_level)
   );

   tx_buffer u_buffer
   (
      .txclk        (txclk),
      .reset        (reset),
      .fifo_data    (fifo_data),
      .fifo_empty   (fifo_empty),
      .fifo_pop     (fifo_pop),
      .channels     (channels),
      .txstrobe     (txstrobe),
      .clear_status (clear_status),
      .tx_i_0       (tx_i_0),
      .tx_q_0       (tx_q_0),
      .tx_i_1       (tx_i_1),
      .tx_q_1       (tx_q_1),
      .tx_i_2       (tx_i_2),
      .tx_q_2       (tx_q_2),
      .tx_i_3       (tx_i_3),
      .tx_q_3       (tx_q_3),
      .tx_underrun  (tx_underrun),
      .debugbus     (debugbus)
   );

   // DAC frame rate
   tx_strobe_gen u_strobe
   (
      .txclk     (txclk),
      .reset     (reset),
      .tx_enable (tx_enable),
      .rate      (rate),
      .txstrobe  (txstrobe)
   );

   assign tx_empty = fifo_empty;

endmodule

`default_nettype wire

// ==== testbench/tb_usrp_tx.sv ====
// Testbench for usrp_tx_top: clock, reset, LFSR stimulus, reference model, assertions, watchdog
`timescale 1ns/1ps
`default_nettype none

`include "usrp_tx_settings.svh"

module tb_usrp_tx;

   localparam int CLK_PERIOD  = 8;
   localparam int SPACE_LIMIT = `TX_FIFO_DEPTH - 1 - `TX_PACKET_WORDS;
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
   // Stimulus sizes, also used to size the watchdog
   localparam int FRAME_WORDS = 64;
   localparam int GUARD_WORDS = 320;
   localparam int SPACE_WORDS = 15 * `TX_PACKET_WORDS;
   localparam int WATCHDOG_CYCLES =
      3 * FRAME_WORDS * 24 + GUARD_WORDS * 10 + SPACE_WORDS * 3 + 1000;

   logic                      txclk;
   logic                      reset;
   logic                      bus_reset;
   usrp_tx_pkg::sample_t      usbdata;
   logic                      wr;
   logic                      have_space;
   usrp_tx_pkg::slot_t        channels;
   usrp_tx_pkg::rate_t        rate;
   logic                      tx_enable;
   logic                      clear_status;
   usrp_tx_pkg::sample_t      tx_i_0, tx_q_0, tx_i_1, tx_q_1;
   usrp_tx_pkg::sample_t      tx_i_2, tx_q_2, tx_i_3, tx_q_3;
   logic                      tx_underrun;
   logic                      tx_empty;
   logic [11:0]               debugbus;
   logic [127:0]              dut_slots;

   // Reference model state, reflects the DUT after the most recent edge
   usrp_tx_pkg::sample_t      m_q [$];
   usrp_tx_pkg::sample_t      m_slot [`TX_NUM_SLOTS];
   usrp_tx_pkg::slot_t        m_next;
   usrp_tx_pkg::rate_t        m_ticks;
   logic                      m_strobe;
   logic                      m_underrun;
   int                        m_burst;
   bit                        model_valid = 1'b0;
   logic [31:0]               lfsr = 32'hb4b3_3122;

   usrp_tx_top u_dut
   (
      .txclk (txclk), .reset (reset), .bus_reset (bus_reset),
      .usbdata (usbdata), .wr (wr), .have_space (have_space),
      .channels (channels), .rate (rate), .tx_enable (tx_enable),
      .clear_status (clear_status),
      .tx_i_0 (tx_i_0), .tx_q_0 (tx_q_0), .tx_i_1 (tx_i_1), .tx_q_1 (tx_q_1),
      .tx_i_2 (tx_i_2), .tx_q_2 (tx_q_2), .tx_i_3 (tx_i_3), .tx_q_3 (tx_q_3),
      .tx_underrun (tx_underrun), .tx_empty (tx_empty), .debugbus (debugbus)
   );

   // Slot order i0 q0 i1 q1 i2 q2 i3 q3, slot 0 in the low bits
   assign dut_slots = {tx_q_3, tx_i_3, tx_q_2, tx_i_2, tx_q_1, tx_i_1, tx_q_0, tx_i_0};

   initial
   begin
      txclk = 1'b0;
      forever #(CLK_PERIOD / 2) txclk = ~txclk;
   end

   task automatic end_with_failure();
      $display("=== FAIL ===");
      $fatal(1, "Simulation stopped after a failure");
   endtask

   task automatic report_mismatch(input string msg);
      $display("ERROR at %0t ns: %s", $time, msg);
      end_with_failure();
   endtask

   task automatic abort_run(input string msg);
      $display("%s", msg);
      end_with_failure();
   endtask

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] bits;
      bits = '0;
      for (int i = 0; i < n; i++)
      begin
         bits = {bits[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
      end
      return bits;
   endfunction

   // Compare every observable output with the model
   task automatic check_outputs();
      logic exp_pop;
      // Head word is taken while the frame has room and words are waiting
      exp_pop = (m_next != channels) && (m_q.size() != 0);
      for (int i = 0; i < `TX_NUM_SLOTS; i++)
      begin
         assert (dut_slots[16*i +: 16] == m_slot[i])
         else report_mismatch($sformatf("slot %0d holds %h, expected %h",
                                        i, dut_slots[16*i +: 16], m_slot[i]));
      end
      assert (debugbus[0] == exp_pop)
      else report_mismatch($sformatf("fifo_pop is %b, expected %b", debugbus[0], exp_pop));
      assert (debugbus[1] == (m_q.size() == 0))
      else report_mismatch($sformatf("debug fifo_empty is %b with %0d words queued",
                                     debugbus[1], m_q.size()));
      assert (debugbus[3] == m_underrun)
      else report_mismatch($sformatf("debug tx_underrun is %b, expected %b",
                                     debugbus[3], m_underrun));
      assert (debugbus[11:8] == m_next)
      else report_mismatch($sformatf("load_next is %0d, expected %0d", debugbus[11:8], m_next));
      assert (debugbus[2] == m_strobe)
      else report_mismatch($sformatf("txstrobe is %b, expected %b", debugbus[2], m_strobe));
      assert (tx_underrun == m_underrun)
      else report_mismatch($sformatf("tx_underrun is %b, expected %b", tx_underrun, m_underrun));
      assert (tx_empty == (m_q.size() == 0))
      else report_mismatch($sformatf("tx_empty is %b with %0d words queued", tx_empty, m_q.size()));
      assert (have_space == (m_q.size() <= SPACE_LIMIT))
      else report_mismatch($sformatf("have_space is %b with %0d words queued",
                                     have_space, m_q.size()));
   endtask

   // Advance the model across the coming edge, from the inputs held for it
   task automatic update_model();
      logic pop;
      logic accept;
      pop    = (m_next != channels) && (m_q.size() != 0);
      // Only the first packet's worth of a burst gets in
      accept = wr && (m_burst < `TX_PACKET_WORDS);
      if (reset)
      begin
         m_q.delete();
         m_next     = '0;
         m_underrun = 1'b0;
         for (int i = 0; i < `TX_NUM_SLOTS; i++)
         begin
            m_slot[i] = '0;
         end
      end
      else
      begin
         // Strobe before the frame is complete
         if (m_strobe && (m_next != channels))
            m_underrun = 1'b1;
         else if (clear_status)
            m_underrun = 1'b0;
         if (pop)
         begin
            if (int'(m_next) < `TX_NUM_SLOTS)
               m_slot[m_next[2:0]] = m_q.pop_front();
            else
               void'(m_q.pop_front());
            m_next = m_next + 1'b1;
         end
         else if (m_strobe && (m_next == channels))
         begin
            m_next = '0;
         end
         // Written word is visible only after the edge, so after the pop
         if (accept)
            m_q.push_back(usbdata);
      end
      if (bus_reset)
         m_burst = 0;
      else if (accept)
         m_burst++;
      else if (!wr)
         m_burst = 0;
      // One strobe every rate + 1 enabled edges
      if (reset || !tx_enable)
      begin
         m_ticks  = '0;
         m_strobe = 1'b0;
      end
      else if (m_ticks == rate)
      begin
         m_ticks  = '0;
         m_strobe = 1'b1;
      end
      else
      begin
         m_ticks  = m_ticks + 1'b1;
         m_strobe = 1'b0;
      end
   endtask

   // Outputs and inputs are both settled at the falling edge
   always @(negedge txclk)
   begin
      if (model_valid)
         check_outputs();
      update_model();
      model_valid = 1'b1;
   end

   underrun_sticky: assert property (@(posedge txclk) disable iff (reset)
      (tx_underrun && !clear_status) |=> tx_underrun)
   else report_mismatch("tx_underrun dropped without clear_status");

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      abort_run("Watchdog expired before the test sequence finished");
   end

   task automatic next_cycle();
      @(posedge txclk);
      #1;
   endtask

   task automatic reset_dut();
      reset        = 1'b1;
      bus_reset    = 1'b1;
      wr           = 1'b0;
      tx_enable    = 1'b0;
      clear_status = 1'b0;
      channels     = '0;
      repeat (3) next_cycle();
      reset     = 1'b0;
      bus_reset = 1'b0;
      next_cycle();
      assert ((dut_slots == '0) && !tx_underrun && tx_empty && have_space)
      else report_mismatch("outputs after reset differ from the reset state");
   endtask

   // Burst of random words, then an idle gap that rearms the guard
   task automatic write_burst(input int words, input int gap);
      for (int i = 0; i < words; i++)
      begin
         wr      = 1'b1;
         usbdata = usrp_tx_pkg::sample_t'(rand_bits(16));
         next_cycle();
      end
      wr = 1'b0;
      repeat (gap) next_cycle();
   endtask

   // Done once the FIFO is empty and the current frame is complete
   task automatic wait_drained(input int limit);
      int n;
      n = 0;
      while (!(tx_empty && (debugbus[11:8] == channels)))
      begin
         if (n == limit)
            abort_run("The sample FIFO did not drain within the expected time");
         n++;
         next_cycle();
      end
      repeat (4) next_cycle();
   endtask

   initial
   begin
      int n;
      int ch_list [3];
      ch_list      = '{8, 4, 2};
      reset        = 1'b1;
      bus_reset    = 1'b1;
      usbdata      = '0;
      wr           = 1'b0;
      channels     = '0;
      rate         = '0;
      tx_enable    = 1'b0;
      clear_status = 1'b0;
      reset_dut();

      // Frame ordering with 8, 4 and 2 channels
      // Narrower frames leave the upper slots as the wider frame left them
      foreach (ch_list[k])
      begin
         channels = usrp_tx_pkg::slot_t'(ch_list[k]);
         rate     = usrp_tx_pkg::rate_t'(rand_bits(4) + 32'(ch_list[k]));
         next_cycle();
         tx_enable = 1'b1;
         for (int b = 0; b < 4; b++)
         begin
            write_burst(FRAME_WORDS / 4, 1 + int'(rand_bits(3)));
         end
         wait_drained(FRAME_WORDS * 24);
         // Channel count changes only at slot 0 with the strobe stopped
         n = 0;
         while (debugbus[11:8] != '0)
         begin
            if (n == 32)
               abort_run("load_next did not return to slot 0 after the last frame");
            n++;
            next_cycle();
         end
         tx_enable = 1'b0;
      end

      // Oversized burst, words past one packet are dropped
      reset_dut();
      channels = 4;
      rate     = 7;
      next_cycle();
      tx_enable = 1'b1;
      write_burst(300, 3);
      write_burst(GUARD_WORDS - 300, 1);
      wait_drained(GUARD_WORDS * 10);

      // Fill with the loader stopped until have_space falls
      reset_dut();
      n = 0;
      while (have_space)
      begin
         if (n == 20)
            abort_run("have_space never fell while the FIFO was filling");
         write_burst(`TX_PACKET_WORDS, 1);
         n++;
      end
      assert (m_q.size() > SPACE_LIMIT)
      else report_mismatch($sformatf("have_space fell with %0d words queued", m_q.size()));
      // Drain with full frames
      channels = 8;
      rate     = 8;
      next_cycle();
      tx_enable = 1'b1;
      wait_drained(SPACE_WORDS * 2);
      assert (have_space)
      else report_mismatch("have_space did not rise after draining");

      // Underrun with an empty FIFO
      reset_dut();
      channels = 2;
      rate     = 3;
      next_cycle();
      tx_enable = 1'b1;
      n = 0;
      while (!tx_underrun)
      begin
         if (n == 32)
            abort_run("tx_underrun never rose with the strobe running on an empty FIFO");
         n++;
         next_cycle();
      end
      repeat (10) next_cycle();
      tx_enable = 1'b0;
      repeat (2) next_cycle();
      clear_status = 1'b1;
      next_cycle();
      clear_status = 1'b0;
      assert (!tx_underrun)
      else report_mismatch("tx_underrun still set one cycle after clear_status");
      repeat (4) next_cycle();

      $display("=== PASS ===");
      $finish;
   end

endmodule

`default_nettype wire

// ==== usrp_tx.f ====
+incdir+include
src/usrp_tx_pkg.sv
src/tx_strobe_gen.sv
src/tx_packet_guard.sv
src/tx_sample_fifo.sv
src/tx_buffer.sv
src/usrp_tx_top.sv
testbench/tb_usrp_tx.sv

// ==== Makefile ====
# Verilator flow for the transmit path: lint the RTL, run the testbench, clean up

OBJ_DIR := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f usrp_tx.f --top-module usrp_tx_top

# The binary exits nonzero when the testbench stops with $fatal
sim:
	verilator --binary --timing --assert -f usrp_tx.f --top-module tb_usrp_tx -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/Vtb_usrp_tx

clean:
	rm -rf $(OBJ_DIR)
